//--- hdl/drive_channel.sv
// One drive motor, control byte at BASE_ADDR and status byte at BASE_ADDR + 1
// Control also takes the drive and all-motor broadcast writes

`timescale 1ns/1ps

module drive_channel import motor_regs_pkg::*; #(
    parameter addr_t BASE_ADDR = DRIVE_BASE
) (
    reg_bus_if.target   bus,
    input  logic        clock,
    input  logic        arst_n,
    input  logic        fault,       // Driver fault flag
    input  logic [TEMP_W-1:0] temp,  // ADC temperature
    output logic        brake,
    output logic        enable,
    output logic        direction,
    output logic [PWM_W-1:0] pwm,
    output data_t       rd_word      // Zero unless address is ours
);

    localparam addr_t CTRL_ADDR   = BASE_ADDR;
    localparam addr_t STATUS_ADDR = addr_t'(BASE_ADDR + 1);

    motor_ctrl_t ctrl_q;
    data_t       status_q;
    logic        ctrl_wr;

    // Own address or either broadcast that covers drives
    assign ctrl_wr = bus.write_en && ((bus.address == CTRL_ADDR)
                                   || (bus.address == ADDR_BCAST_DRIVE)
                                   || (bus.address == ADDR_BCAST_ALL));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q   <= '0;
            status_q <= '0;
        end else begin
            if (ctrl_wr)
                ctrl_q <= motor_ctrl_t'(bus.wr_data);
            status_q <= {fault, temp};  // Sampled every clock
        end
    end

    // Field decode
    assign brake     = ctrl_q.brake;
    assign enable    = ctrl_q.enable;
    assign direction = ctrl_q.direction;
    assign pwm       = ctrl_q.low;

    always_comb begin
        rd_word = '0;
        if (bus.address == CTRL_ADDR)
            rd_word = data_t'(ctrl_q);
        else if (bus.address == STATUS_ADDR)
            rd_word = status_q;
    end

endmodule

//--- hdl/motor_regs.sv
// Host register block for the swerve drive controller
// NUM_DRIVE and NUM_ROT range 1 to 4; per-motor ports are indexed by channel
// Read data returns one cycle after read_en, writes land one cycle after write_en

`timescale 1ns/1ps

module motor_regs import motor_regs_pkg::*; #(
    parameter int NUM_DRIVE = 4,
    parameter int NUM_ROT   = 4
) (
    input  logic        clock,
    input  logic        arst_n,

    // Host bus
    input  addr_t       address,
    input  logic        write_en,
    input  data_t       wr_data,
    input  logic        read_en,
    output data_t       rd_data,

    // Drive motors
    input  logic [NUM_DRIVE-1:0]             drive_fault,
    input  logic [NUM_DRIVE-1:0][TEMP_W-1:0] drive_temp,
    output logic [NUM_DRIVE-1:0]             drive_brake,
    output logic [NUM_DRIVE-1:0]             drive_enable,
    output logic [NUM_DRIVE-1:0]             drive_direction,
    output logic [NUM_DRIVE-1:0][PWM_W-1:0]  drive_pwm,

    // Rotation motors
    input  logic [NUM_ROT-1:0]               rot_fault,
    input  logic [NUM_ROT-1:0][TEMP_W-1:0]   rot_temp,
    input  logic [NUM_ROT-1:0]               rot_startup_fail,
    input  angle_t [NUM_ROT-1:0]             current_angle,
    input  logic [NUM_ROT-1:0]               angle_done,
    output logic [NUM_ROT-1:0]               rot_brake,
    output logic [NUM_ROT-1:0]               rot_enable,
    output logic [NUM_ROT-1:0]               rot_direction,
    output angle_t [NUM_ROT-1:0]             target_angle,
    output logic [NUM_ROT-1:0]               update_angle,
    output logic [NUM_ROT-1:0]               abort_angle
);

    localparam int N_WORDS = NUM_DRIVE + NUM_ROT;

    reg_bus_if bus ();

    data_t rd_words [N_WORDS];  // Drives first, then rotations

    // Pins onto the internal bus
    assign bus.address  = address;
    assign bus.write_en = write_en;
    assign bus.wr_data  = wr_data;
    assign bus.read_en  = read_en;

    for (genvar g = 0; g < NUM_DRIVE; g++) begin : g_drive
        drive_channel #(
            .BASE_ADDR (addr_t'(DRIVE_BASE + 2 * g))
        ) u_drive (
            .bus       (bus),
            .clock     (clock),
            .arst_n    (arst_n),
            .fault     (drive_fault[g]),
            .temp      (drive_temp[g]),
            .brake     (drive_brake[g]),
            .enable    (drive_enable[g]),
            .direction (drive_direction[g]),
            .pwm       (drive_pwm[g]),
            .rd_word   (rd_words[g])
        );
    end

    for (genvar g = 0; g < NUM_ROT; g++) begin : g_rot
        rotation_channel #(
            .BASE_ADDR (addr_t'(ROT_BASE + ROT_STRIDE * g))
        ) u_rot (
            .bus           (bus),
            .clock         (clock),
            .arst_n        (arst_n),
            .fault         (rot_fault[g]),
            .startup_fail  (rot_startup_fail[g]),
            .temp          (rot_temp[g]),
            .current_angle (current_angle[g]),
            .angle_done    (angle_done[g]),
            .brake         (rot_brake[g]),
            .enable        (rot_enable[g]),
            .direction     (rot_direction[g]),
            .target_angle  (target_angle[g]),
            .update_angle  (update_angle[g]),
            .abort_angle   (abort_angle[g]),
            .rd_word       (rd_words[NUM_DRIVE + g])
        );
    end

    read_return #(
        .N_WORDS (N_WORDS)
    ) u_read_return (
        .bus     (bus),
        .clock   (clock),
        .arst_n  (arst_n),
        .words   (rd_words),
        .rd_data (rd_data)
    );

endmodule

//--- hdl/motor_regs_pkg.sv
// Address map, field widths and control byte layout of the motor register block
// Address 0x00 is reserved; writes to it are dropped and reads return zero
// Map assumes at most four drive and four rotation channels below 0x20

package motor_regs_pkg;

    // Bus and field widths
    localparam int ADDR_W  = 6;
    localparam int DATA_W  = 8;
    localparam int ANGLE_W = 12;   // Rotation angle, 12 bit encoder
    localparam int TEMP_W  = 7;    // ADC temperature
    localparam int PWM_W   = 5;    // Drive PWM field in control byte

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [ANGLE_W-1:0] angle_t;

    // Broadcast write addresses
    localparam addr_t ADDR_BCAST_ALL   = 6'h01;  // Every motor
    localparam addr_t ADDR_BCAST_ROT   = 6'h02;  // Rotation motors only
    localparam addr_t ADDR_BCAST_DRIVE = 6'h03;  // Drive motors only

    // Drive channels, control then status, two addresses each
    localparam addr_t DRIVE_BASE = 6'h04;

    // Rotation channels, five addresses each
    localparam addr_t ROT_BASE   = 6'h0C;
    localparam int    ROT_STRIDE = 5;

    // Offsets from a rotation channel base
    localparam int ROT_OFS_CTRL    = 0;
    localparam int ROT_OFS_STATUS  = 1;
    localparam int ROT_OFS_TARGET  = 2;  // Target angle bits 7..0
    localparam int ROT_OFS_CURR_LO = 3;  // Current angle bits 7..0
    localparam int ROT_OFS_CURR_HI = 4;  // Done flag, angle bits 11..8, commands on write

    // Bit positions in the control byte
    localparam int CTRL_BRAKE_BIT  = 7;
    localparam int CTRL_ENABLE_BIT = 6;
    localparam int CTRL_DIR_BIT    = 5;

    // Command bits of a CURR_HI write
    localparam int CMD_ABORT_BIT  = 4;
    localparam int CMD_UPDATE_BIT = 5;

    // Control byte, shared by drive and rotation channels
    // Drive uses low as PWM, rotation uses low[3:0] as target angle 11..8
    typedef struct packed {
        logic             brake;      // Bit 7
        logic             enable;     // Bit 6
        logic             direction;  // Bit 5
        logic [PWM_W-1:0] low;        // Bits 4..0
    } motor_ctrl_t;

endpackage

//--- hdl/read_return.sv
// Read data path, one cycle latency from read_en
// Channel words must be zero when the channel does not own the address

`timescale 1ns/1ps

module read_return import motor_regs_pkg::*; #(
    parameter int N_WORDS = 8
) (
    reg_bus_if.target   bus,
    input  logic        clock,
    input  logic        arst_n,
    input  data_t       words [N_WORDS],  // One word per channel
    output data_t       rd_data           // Held while read_en is low
);

    data_t read_mux;

    // At most one channel is nonzero, so an OR works as the mux
    // Unmapped addresses fall out as zero
    always_comb begin
        read_mux = '0;
        for (int i = 0; i < N_WORDS; i++) begin
            read_mux = read_mux | words[i];
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            rd_data <= '0;
        else if (bus.read_en)
            rd_data <= read_mux;  // Load on read strobe
    end

endmodule

//--- hdl/reg_bus_if.sv
// Host register bus, byte wide, no handshake
// Every strobe is accepted in the cycle it is high

`timescale 1ns/1ps

interface reg_bus_if import motor_regs_pkg::*; ();

    addr_t address;   // Read and write address
    logic  write_en;  // Write strobe, one write per high cycle
    data_t wr_data;   // Write data
    logic  read_en;   // Read strobe, sampled every high cycle

    // Top level drives the bus from its pins
    modport host (
        output address,
        output write_en,
        output wr_data,
        output read_en
    );

    // Channels and read path only observe
    modport target (
        input address,
        input write_en,
        input wr_data,
        input read_en
    );

endinterface

//--- hdl/rotation_channel.sv
// One rotation motor, five addresses from BASE_ADDR: ctrl, status, target, curr lo, curr hi
// Target low byte has no broadcast; a CURR_HI write issues one-cycle command pulses
// Temperature is reported on 6 bits, bit 6 is not kept

`timescale 1ns/1ps

module rotation_channel import motor_regs_pkg::*; #(
    parameter addr_t BASE_ADDR = ROT_BASE
) (
    reg_bus_if.target   bus,
    input  logic        clock,
    input  logic        arst_n,
    input  logic        fault,          // Driver fault flag
    input  logic        startup_fail,   // Motor stalled at startup
    input  logic [TEMP_W-1:0] temp,     // ADC temperature
    input  angle_t      current_angle,  // Encoder angle
    input  logic        angle_done,     // Arrived at target
    output logic        brake,
    output logic        enable,
    output logic        direction,
    output angle_t      target_angle,
    output logic        update_angle,   // One cycle, start move
    output logic        abort_angle,    // One cycle, stop move
    output data_t       rd_word         // Zero unless address is ours
);

    localparam addr_t CTRL_ADDR    = addr_t'(BASE_ADDR + ROT_OFS_CTRL);
    localparam addr_t STATUS_ADDR  = addr_t'(BASE_ADDR + ROT_OFS_STATUS);
    localparam addr_t TARGET_ADDR  = addr_t'(BASE_ADDR + ROT_OFS_TARGET);
    localparam addr_t CURR_LO_ADDR = addr_t'(BASE_ADDR + ROT_OFS_CURR_LO);
    localparam addr_t CURR_HI_ADDR = addr_t'(BASE_ADDR + ROT_OFS_CURR_HI);
    localparam int    HI_W         = ANGLE_W - DATA_W;  // Angle bits above the target byte

    motor_ctrl_t ctrl_q;
    data_t       target_q;
    data_t       status_q;
    data_t       curr_lo_q;
    data_t       curr_hi_q;
    logic        ctrl_wr;
    logic        target_wr;
    logic        cmd_wr;

    assign ctrl_wr   = bus.write_en && ((bus.address == CTRL_ADDR)
                                     || (bus.address == ADDR_BCAST_ROT)
                                     || (bus.address == ADDR_BCAST_ALL));
    assign target_wr = bus.write_en && (bus.address == TARGET_ADDR);  // No broadcast
    assign cmd_wr    = bus.write_en && (bus.address == CURR_HI_ADDR);

    // Host written registers
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q   <= '0;
            target_q <= '0;
        end else begin
            if (ctrl_wr)
                ctrl_q <= motor_ctrl_t'(bus.wr_data);
            if (target_wr)
                target_q <= bus.wr_data;
        end
    end

    // Status side, sampled every clock
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            status_q  <= '0;
            curr_lo_q <= '0;
            curr_hi_q <= '0;
        end else begin
            status_q  <= {fault, startup_fail, temp[5:0]};
            curr_lo_q <= current_angle[DATA_W-1:0];
            curr_hi_q <= {angle_done, 3'b000, current_angle[ANGLE_W-1:DATA_W]};
        end
    end

    // Command pulses, high only in the cycle after the write
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            update_angle <= 1'b0;
            abort_angle  <= 1'b0;
        end else begin
            update_angle <= cmd_wr && bus.wr_data[CMD_UPDATE_BIT];
            abort_angle  <= cmd_wr && bus.wr_data[CMD_ABORT_BIT];
        end
    end

    assign brake        = ctrl_q.brake;
    assign enable       = ctrl_q.enable;
    assign direction    = ctrl_q.direction;
    assign target_angle = {ctrl_q.low[HI_W-1:0], target_q};  // Ctrl bits 3..0 on top

    always_comb begin
        case (bus.address)
            CTRL_ADDR:    rd_word = data_t'(ctrl_q);
            STATUS_ADDR:  rd_word = status_q;
            TARGET_ADDR:  rd_word = target_q;
            CURR_LO_ADDR: rd_word = curr_lo_q;
            CURR_HI_ADDR: rd_word = curr_hi_q;
            default:      rd_word = '0;
        endcase
    end

endmodule

//--- motor_regs.f
hdl/motor_regs_pkg.sv
hdl/reg_bus_if.sv
hdl/drive_channel.sv
hdl/rotation_channel.sv
hdl/read_return.sv
hdl/motor_regs.sv
verification/motor_regs_props.sv
verification/motor_regs_tb.sv

//--- verification/motor_regs_props.sv
// Bound into every rotation_channel instance
// Command writes are decoded from the host bus at the channel's CURR_HI address

`timescale 1ns/1ps

module motor_regs_props import motor_regs_pkg::*; #(
    parameter addr_t CMD_ADDR = addr_t'(ROT_BASE + ROT_OFS_CURR_HI)  // Channel's CURR_HI
) (
    input logic   clock,
    input logic   arst_n,
    input logic   write_en,      // Host bus as the channel sees it
    input addr_t  address,
    input data_t  wr_data,
    input logic   update_angle,
    input logic   abort_angle,
    input logic   brake,
    input logic   enable,
    input logic   direction,
    input angle_t target_angle
);

    int   assert_fails = 0;
    logic cmd_write;

    assign cmd_write = write_en && (address == CMD_ADDR);  // Host write to CURR_HI

    // Second high cycle only if a fresh command write with the update bit caused it
    a_update_single: assert property (@(posedge clock) disable iff (!arst_n)
        update_angle |=> !update_angle || $past(cmd_write && wr_data[CMD_UPDATE_BIT]))
        else begin
            $error("update_angle held high without a new command write");
            assert_fails++;
        end

    a_abort_single: assert property (@(posedge clock) disable iff (!arst_n)
        abort_angle |=> !abort_angle || $past(cmd_write && wr_data[CMD_ABORT_BIT]))
        else begin
            $error("abort_angle held high without a new command write");
            assert_fails++;
        end

    // First sampled cycle out of reset
    a_quiet_after_reset: assert property (@(posedge clock)
        $rose(arst_n) |-> !update_angle && !abort_angle)
        else begin
            $error("command pulse active right after reset release");
            assert_fails++;
        end

    a_ctrl_in_reset: assert property (@(posedge clock)
        !arst_n |-> !brake && !enable && !direction && (target_angle == '0))
        else begin
            $error("control outputs not cleared while reset is asserted");
            assert_fails++;
        end

endmodule

bind rotation_channel motor_regs_props #(
    .CMD_ADDR (addr_t'(BASE_ADDR + ROT_OFS_CURR_HI))
) u_props (
    .clock        (clock),
    .arst_n       (arst_n),
    .write_en     (bus.write_en),
    .address      (bus.address),
    .wr_data      (bus.wr_data),
    .update_angle (update_angle),
    .abort_angle  (abort_angle),
    .brake        (brake),
    .enable       (enable),
    .direction    (direction),
    .target_angle (target_angle)
);

//--- verification/motor_regs_tb.sv
// Directed testbench for motor_regs at the default channel counts, four drive and four rotation
// Writes and reads both take one clock; status inputs are held steady while they are read

`timescale 1ns/1ps

module motor_regs_tb import motor_regs_pkg::*; ();

    localparam int NUM_DRIVE = 4;
    localparam int NUM_ROT   = 4;
    localparam int READ_LAT  = 1;  // Clocks from read strobe to rd_data

    logic                             clock;
    logic                             arst_n;
    addr_t                            address;
    logic                             write_en;
    data_t                            wr_data;
    logic                             read_en;
    data_t                            rd_data;
    logic [NUM_DRIVE-1:0]             drive_fault;
    logic [NUM_DRIVE-1:0][TEMP_W-1:0] drive_temp;
    logic [NUM_DRIVE-1:0]             drive_brake;
    logic [NUM_DRIVE-1:0]             drive_enable;
    logic [NUM_DRIVE-1:0]             drive_direction;
    logic [NUM_DRIVE-1:0][PWM_W-1:0]  drive_pwm;
    logic [NUM_ROT-1:0]               rot_fault;
    logic [NUM_ROT-1:0][TEMP_W-1:0]   rot_temp;
    logic [NUM_ROT-1:0]               rot_startup_fail;
    angle_t [NUM_ROT-1:0]             current_angle;
    logic [NUM_ROT-1:0]               angle_done;
    logic [NUM_ROT-1:0]               rot_brake;
    logic [NUM_ROT-1:0]               rot_enable;
    logic [NUM_ROT-1:0]               rot_direction;
    angle_t [NUM_ROT-1:0]             target_angle;
    logic [NUM_ROT-1:0]               update_angle;
    logic [NUM_ROT-1:0]               abort_angle;

    // Expected register contents
    data_t drive_ctrl_m [NUM_DRIVE] = '{default: '0};
    data_t rot_ctrl_m   [NUM_ROT]   = '{default: '0};
    data_t target_m     [NUM_ROT]   = '{default: '0};
    int    error_count = 0;

    motor_regs uut (.*);

    always #10 clock = ~clock;  // 20 ns period

    function automatic addr_t drive_addr(input int ch);
        return addr_t'(DRIVE_BASE + 2 * ch);  // Control; status is one above
    endfunction

    function automatic addr_t rot_addr(input int ch, input int ofs);
        return addr_t'(ROT_BASE + ROT_STRIDE * ch + ofs);
    endfunction

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic bus_write(input addr_t addr, input data_t data);
        @(posedge clock);
        #1;
        address  = addr;
        wr_data  = data;
        write_en = 1'b1;
        @(posedge clock);  // Register loads here
        #1;
        write_en = 1'b0;
    endtask

    task automatic bus_read(input addr_t addr, output data_t data);
        @(posedge clock);
        #1;
        address = addr;
        read_en = 1'b1;
        for (int i = 0; i < READ_LAT; i++)
            @(posedge clock);
        #1;
        read_en = 1'b0;
        data    = rd_data;
    endtask

    task automatic read_expect(input addr_t addr, input data_t expected, input string name);
        data_t got;
        bus_read(addr, got);
        check_eq(name, got, expected);
    endtask

    // Outputs against the expected bytes, decoded per the control byte layout
    task automatic check_controls();
        for (int i = 0; i < NUM_DRIVE; i++) begin
            check_eq($sformatf("drive_brake[%0d]", i), drive_brake[i],
                     drive_ctrl_m[i][CTRL_BRAKE_BIT]);
            check_eq($sformatf("drive_enable[%0d]", i), drive_enable[i],
                     drive_ctrl_m[i][CTRL_ENABLE_BIT]);
            check_eq($sformatf("drive_direction[%0d]", i), drive_direction[i],
                     drive_ctrl_m[i][CTRL_DIR_BIT]);
            check_eq($sformatf("drive_pwm[%0d]", i), drive_pwm[i], drive_ctrl_m[i][PWM_W-1:0]);
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            check_eq($sformatf("rot_brake[%0d]", i), rot_brake[i], rot_ctrl_m[i][CTRL_BRAKE_BIT]);
            check_eq($sformatf("rot_enable[%0d]", i), rot_enable[i],
                     rot_ctrl_m[i][CTRL_ENABLE_BIT]);
            check_eq($sformatf("rot_direction[%0d]", i), rot_direction[i],
                     rot_ctrl_m[i][CTRL_DIR_BIT]);
            check_eq($sformatf("target_angle[%0d]", i), target_angle[i],
                     {rot_ctrl_m[i][3:0], target_m[i]});  // High nibble from control
        end
        check_eq("update_angle", update_angle, '0);
        check_eq("abort_angle", abort_angle, '0);
    endtask

    task automatic test_reset();
        check_controls();
        for (int i = 0; i < NUM_DRIVE; i++)
            read_expect(drive_addr(i), 8'h00, $sformatf("rd_data drive %0d ctrl", i));
        for (int i = 0; i < NUM_ROT; i++)
            read_expect(rot_addr(i, ROT_OFS_CTRL), 8'h00, $sformatf("rd_data rot %0d ctrl", i));
    endtask

    task automatic test_direct_writes();
        data_t d;
        for (int i = 0; i < NUM_DRIVE; i++) begin
            d = data_t'($urandom);
            bus_write(drive_addr(i), d);
            drive_ctrl_m[i] = d;
            check_controls();
            read_expect(drive_addr(i), d, $sformatf("rd_data drive %0d ctrl", i));
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            d = data_t'($urandom);
            bus_write(rot_addr(i, ROT_OFS_CTRL), d);
            rot_ctrl_m[i] = d;
            check_controls();
            read_expect(rot_addr(i, ROT_OFS_CTRL), d, $sformatf("rd_data rot %0d ctrl", i));
        end
    endtask

    task automatic test_broadcasts();
        data_t d;
        d = data_t'($urandom);
        bus_write(ADDR_BCAST_DRIVE, d);  // Drives only
        foreach (drive_ctrl_m[i]) drive_ctrl_m[i] = d;
        check_controls();
        d = data_t'($urandom);
        bus_write(ADDR_BCAST_ROT, d);  // Rotations only, target byte untouched
        foreach (rot_ctrl_m[i]) rot_ctrl_m[i] = d;
        check_controls();
        d = data_t'($urandom);
        bus_write(ADDR_BCAST_ALL, d);
        foreach (drive_ctrl_m[i]) drive_ctrl_m[i] = d;
        foreach (rot_ctrl_m[i]) rot_ctrl_m[i] = d;
        check_controls();
        read_expect(rot_addr(NUM_ROT - 1, ROT_OFS_CTRL), d, "rd_data after all broadcast");
        bus_write(6'h00, ~d);  // Reserved, dropped
        check_controls();
    endtask

    task automatic test_status();
        repeat (2) begin
            @(posedge clock);
            #1;
            drive_fault      = NUM_DRIVE'($urandom);
            drive_temp       = $urandom;
            rot_fault        = NUM_ROT'($urandom);
            rot_startup_fail = NUM_ROT'($urandom);
            rot_temp         = $urandom;
            current_angle    = {$urandom, $urandom};
            angle_done       = NUM_ROT'($urandom);
            for (int i = 0; i < NUM_DRIVE; i++)
                read_expect(addr_t'(drive_addr(i) + 1), {drive_fault[i], drive_temp[i]},
                            $sformatf("rd_data drive %0d status", i));
            for (int i = 0; i < NUM_ROT; i++) begin
                read_expect(rot_addr(i, ROT_OFS_STATUS),
                            {rot_fault[i], rot_startup_fail[i], rot_temp[i][5:0]},
                            $sformatf("rd_data rot %0d status", i));
                read_expect(rot_addr(i, ROT_OFS_CURR_LO), current_angle[i][7:0],
                            $sformatf("rd_data rot %0d curr lo", i));
                read_expect(rot_addr(i, ROT_OFS_CURR_HI),
                            {angle_done[i], 3'b000, current_angle[i][11:8]},
                            $sformatf("rd_data rot %0d curr hi", i));
            end
        end
    endtask

    task automatic test_angle_commands();
        data_t c;
        data_t t;
        data_t cmd [3] = '{8'h20, 8'h10, 8'h30};  // Update, abort, both
        for (int i = 0; i < NUM_ROT; i++) begin
            c = data_t'($urandom);
            t = data_t'($urandom);
            bus_write(rot_addr(i, ROT_OFS_CTRL), c);
            bus_write(rot_addr(i, ROT_OFS_TARGET), t);
            rot_ctrl_m[i] = c;
            target_m[i]   = t;
            check_controls();
            read_expect(rot_addr(i, ROT_OFS_TARGET), t, $sformatf("rd_data rot %0d target", i));
            for (int k = 0; k < 3; k++) begin
                bus_write(rot_addr(i, ROT_OFS_CURR_HI), cmd[k]);
                check_eq("update_angle", update_angle,
                         cmd[k][CMD_UPDATE_BIT] ? (32'd1 << i) : 32'd0);
                check_eq("abort_angle", abort_angle,
                         cmd[k][CMD_ABORT_BIT] ? (32'd1 << i) : 32'd0);
                @(posedge clock);
                #1;
                check_eq("update_angle", update_angle, '0);  // Gone after one cycle
                check_eq("abort_angle", abort_angle, '0);
            end
        end
    endtask

    task automatic test_unmapped();
        bus_write(drive_addr(0), 8'hc3);
        drive_ctrl_m[0] = 8'hc3;
        read_expect(drive_addr(0), 8'hc3, "rd_data drive 0 ctrl");
        address = 6'h30;  // Strobe low, new address must not leak through
        for (int i = 0; i < 3; i++)
            @(posedge clock);
        #1;
        check_eq("rd_data held", rd_data, 8'hc3);
        read_expect(6'h00, 8'h00, "rd_data addr 0x00");
        read_expect(6'h30, 8'h00, "rd_data addr 0x30");
    endtask

    initial begin
        int assert_fails;
        void'($urandom(32'h3a99));
        clock            = 1'b0;
        arst_n           = 1'b1;
        address          = '0;
        write_en         = 1'b0;
        wr_data          = '0;
        read_en          = 1'b0;
        drive_fault      = '0;
        drive_temp       = '0;
        rot_fault        = '0;
        rot_temp         = '0;
        rot_startup_fail = '0;
        current_angle    = '0;
        angle_done       = '0;
        #1;
        arst_n = 1'b0;
        repeat (8) @(posedge clock);
        #1;
        arst_n = 1'b1;

        test_reset();
        test_direct_writes();
        test_broadcasts();
        test_status();
        test_angle_commands();
        test_unmapped();

        assert_fails = uut.g_rot[0].u_rot.u_props.assert_fails
                     + uut.g_rot[1].u_rot.u_props.assert_fails
                     + uut.g_rot[2].u_rot.u_props.assert_fails
                     + uut.g_rot[3].u_rot.u_props.assert_fails;
        $display("errors: %0d check mismatches, %0d assertion failures",
                 error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule
